//--- wiscPkg.sv
// Kept subset of the teaching ISA only; unlisted opcodes decode as no-ops
`default_nettype none

package wiscPkg;

	localparam int opWidth = 5;
	localparam int wordWidth = 16;
	localparam int regCount = 8;
	localparam int regAddrWidth = 3;
	localparam logic [regAddrWidth-1:0] linkReg = regAddrWidth'(regCount - 1);

	// Immediate and displacement field widths
	localparam int immShortWidth = 5;
	localparam int immLongWidth = 8;
	localparam int dispWidth = 11;

	typedef enum logic [opWidth-1:0] {
		opHalt = 5'b00000,
		opNop  = 5'b00001,
		opJ    = 5'b00100,
		opJal  = 5'b00110,
		opAddi = 5'b01000,
		opSubi = 5'b01001,
		opXori = 5'b01010,
		opAndi = 5'b01011,
		opBeqz = 5'b01100,
		opBnez = 5'b01101,
		opBltz = 5'b01110,
		opBgez = 5'b01111,
		opSt   = 5'b10000,
		opLd   = 5'b10001,
		opSlbi = 5'b10010,
		opStu  = 5'b10011,
		opLbi  = 5'b11000,
		opAlu  = 5'b11011,
		opSeq  = 5'b11100,
		opSlt  = 5'b11101,
		opSle  = 5'b11110
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluRsub, aluXor, aluAnd, aluAndn,
		aluPassB, aluSlbi, aluEq, aluLt, aluLe
	} aluOpT;

endpackage

`default_nettype wire

//--- busPkg.sv
// APB widths are fixed at 16 bits; no pslverr or pprot on this bus
`default_nettype none

package busPkg;

	localparam int addrWidth = 16;
	localparam int dataWidth = 16;

	typedef enum logic [1:0] {
		apbIdle, apbSetup, apbAccess
	} apbStateT;

	// Owner of the external port
	typedef enum logic [1:0] {
		grantNone, grantFetch, grantData
	} grantT;

endpackage

`default_nettype wire

//--- control.sv
// Purely combinational; strobes are only meaningful while the instruction register is stable
`default_nettype none

module control
	import wiscPkg::*;
(
	input wire [wordWidth-1:0] instr,
	output logic regWrite,
	output logic [regAddrWidth-1:0] writeSel,
	output logic aluSrc,
	output aluOpT aluOp,
	output logic extSigned,
	output logic immWide,
	output logic memWrite,
	output logic memRead,
	output logic stuCtl,
	output logic branchCtl,
	output logic jumpCtl,
	output logic linkCtl,
	output logic halt
);

	logic [regAddrWidth-1:0] rsField;
	logic [regAddrWidth-1:0] rdIField;
	logic [regAddrWidth-1:0] rdRField;

	assign rsField = instr[10:8];
	assign rdIField = instr[7:5];
	assign rdRField = instr[4:2];

	always_comb begin
		// Defaults describe a no-op
		regWrite = 1'b0;
		writeSel = rdIField;
		aluSrc = 1'b0;
		aluOp = aluAdd;
		extSigned = 1'b0;
		immWide = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		stuCtl = 1'b0;
		branchCtl = 1'b0;
		jumpCtl = 1'b0;
		linkCtl = 1'b0;
		halt = 1'b0;

		case (opcodeT'(instr[wordWidth-1 -: opWidth]))
			opHalt: halt = 1'b1;
			opAddi, opSubi, opXori, opAndi: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				extSigned = (instr[12] == 1'b0);
				case (instr[12:11])
					2'b00: aluOp = aluAdd;
					2'b01: aluOp = aluRsub;
					2'b10: aluOp = aluXor;
					default: aluOp = aluAnd;
				endcase
			end
			opSt, opLd, opStu: begin
				aluSrc = 1'b1;
				extSigned = 1'b1;
				memWrite = (instr[11] == 1'b0) || (instr[12] == 1'b1);
				memRead = (instr[12:11] == 2'b01);
				regWrite = (instr[11] == 1'b1);
				stuCtl = (instr[12] == 1'b1);
				// stu writes the updated base back to Rs
				if (instr[12])
					writeSel = rsField;
			end
			opLbi, opSlbi: begin
				regWrite = 1'b1;
				aluSrc = 1'b1;
				immWide = 1'b1;
				writeSel = rsField;
				extSigned = (instr[15:11] == opLbi);
				aluOp = (instr[15:11] == opLbi) ? aluPassB : aluSlbi;
			end
			opAlu: begin
				regWrite = 1'b1;
				writeSel = rdRField;
				case (instr[1:0])
					2'b00: aluOp = aluAdd;
					2'b01: aluOp = aluRsub;
					2'b10: aluOp = aluXor;
					default: aluOp = aluAndn;
				endcase
			end
			opSeq, opSlt, opSle: begin
				regWrite = 1'b1;
				writeSel = rdRField;
				case (instr[12:11])
					2'b00: aluOp = aluEq;
					2'b01: aluOp = aluLt;
					default: aluOp = aluLe;
				endcase
			end
			opBeqz, opBnez, opBltz, opBgez: branchCtl = 1'b1;
			opJ: jumpCtl = 1'b1;
			opJal: begin
				jumpCtl = 1'b1;
				linkCtl = 1'b1;
				regWrite = 1'b1;
				writeSel = linkReg;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- regFile.sv
// Reads are combinational and see the pre-write value in a write cycle
`default_nettype none

module regFile
	import wiscPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire [regAddrWidth-1:0] readAddrA,
	input wire [regAddrWidth-1:0] readAddrB,
	input wire [regAddrWidth-1:0] writeAddr,
	input wire writeEn,
	input wire [wordWidth-1:0] writeData,
	output logic [wordWidth-1:0] readDataA,
	output logic [wordWidth-1:0] readDataB
);

	logic [wordWidth-1:0] regs [regCount];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end else if (writeEn) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

//--- alu.sv
// Sets and branch tests are signed; rotates and shifts are not implemented
`default_nettype none

module alu
	import wiscPkg::*;
(
	input wire [wordWidth-1:0] instr,
	input wire aluOpT aluOp,
	input wire aluSrc,
	input wire extSigned,
	input wire immWide,
	input wire [wordWidth-1:0] regA,
	input wire [wordWidth-1:0] regB,
	output logic [wordWidth-1:0] result,
	output logic branchTaken
);

	logic [immShortWidth-1:0] immShort;
	logic [immLongWidth-1:0] immLong;
	logic [wordWidth-1:0] imm;
	logic [wordWidth-1:0] opB;

	assign immShort = instr[immShortWidth-1:0];
	assign immLong = instr[immLongWidth-1:0];

	always_comb begin
		if (immWide)
			imm = {{(wordWidth-immLongWidth){extSigned & immLong[immLongWidth-1]}}, immLong};
		else
			imm = {{(wordWidth-immShortWidth){extSigned & immShort[immShortWidth-1]}}, immShort};
	end

	assign opB = aluSrc ? imm : regB;

	always_comb begin
		case (aluOp)
			aluAdd: result = regA + opB;
			// Second operand minus first
			aluRsub: result = opB - regA;
			aluXor: result = regA ^ opB;
			aluAnd: result = regA & opB;
			aluAndn: result = regA & ~opB;
			aluPassB: result = opB;
			aluSlbi: result = (regA << 8) | opB;
			aluEq: result = wordWidth'(regA == opB);
			aluLt: result = wordWidth'($signed(regA) < $signed(opB));
			aluLe: result = wordWidth'($signed(regA) <= $signed(opB));
			default: result = '0;
		endcase
	end

	// Condition only, qualified by branchCtl in the sequencer
	always_comb begin
		case (opcodeT'(instr[wordWidth-1 -: opWidth]))
			opBeqz: branchTaken = (regA == '0);
			opBnez: branchTaken = (regA != '0);
			opBltz: branchTaken = regA[wordWidth-1];
			opBgez: branchTaken = ~regA[wordWidth-1];
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- fetchSequencer.sv
// Read-only APB requester; next instruction is prefetched during memory instructions only
`default_nettype none

module fetchSequencer
	import wiscPkg::*;
	import busPkg::*;
(
	input wire clk,
	input wire rstN,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [addrWidth-1:0] paddr,
	output logic [dataWidth-1:0] pwdata,
	input wire [dataWidth-1:0] prdata,
	input wire pready,
	input wire memBusy,
	input wire memDone,
	input wire branchCtl,
	input wire jumpCtl,
	input wire linkCtl,
	input wire halt,
	input wire memRead,
	input wire memWrite,
	input wire branchTaken,
	output logic [wordWidth-1:0] instr,
	output logic execStep,
	output logic [addrWidth-1:0] pcPlus2,
	output logic halted
);

	typedef enum logic [1:0] {
		seqFetch, seqExec, seqWaitMem, seqHalted
	} seqStateT;

	seqStateT state;
	apbStateT apbState;
	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] fetchAddr;
	logic [addrWidth-1:0] nextPc;
	logic [addrWidth-1:0] branchOffset;
	logic [addrWidth-1:0] jumpOffset;
	logic [wordWidth-1:0] holdInstr;
	logic holdValid;
	logic fetchComplete;
	logic memFinished;

	assign pcPlus2 = pc + addrWidth'(2);
	assign branchOffset = {{(addrWidth-immLongWidth){instr[immLongWidth-1]}},
		instr[immLongWidth-1:0]};
	assign jumpOffset = {{(addrWidth-dispWidth){instr[dispWidth-1]}}, instr[dispWidth-1:0]};

	// jal links through the writeback path and jumps like j
	always_comb begin
		nextPc = pcPlus2;
		if (jumpCtl || linkCtl)
			nextPc = pcPlus2 + jumpOffset;
		else if (branchCtl && branchTaken)
			nextPc = pcPlus2 + branchOffset;
	end

	assign psel = (apbState != apbIdle);
	assign penable = (apbState == apbAccess);
	assign pwrite = 1'b0;
	assign paddr = fetchAddr;
	assign pwdata = '0;

	assign fetchComplete = penable & pready;
	assign memFinished = memDone | ~memBusy;
	assign execStep = (state == seqExec);
	assign halted = (state == seqHalted);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= seqFetch;
			apbState <= apbIdle;
			pc <= '0;
			fetchAddr <= '0;
			instr <= {opNop, {(wordWidth-opWidth){1'b0}}};
			holdInstr <= '0;
			holdValid <= 1'b0;
		end else begin
			case (apbState)
				apbSetup: apbState <= apbAccess;
				apbAccess: if (pready) apbState <= apbIdle;
				default: begin
				end
			endcase

			case (state)
				seqFetch: begin
					// First fetch after reset
					if (apbState == apbIdle) begin
						apbState <= apbSetup;
						fetchAddr <= pc;
					end
					if (fetchComplete) begin
						instr <= prdata;
						state <= seqExec;
					end
				end
				seqExec: begin
					if (halt) begin
						state <= seqHalted;
					end else begin
						pc <= nextPc;
						fetchAddr <= nextPc;
						apbState <= apbSetup;
						state <= (memRead || memWrite) ? seqWaitMem : seqFetch;
					end
				end
				seqWaitMem: begin
					if (fetchComplete) begin
						holdInstr <= prdata;
						holdValid <= 1'b1;
					end
					// Both the data transfer and the prefetch must be done
					if ((holdValid || fetchComplete) && memFinished) begin
						instr <= holdValid ? holdInstr : prdata;
						holdValid <= 1'b0;
						state <= seqExec;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- memUnit.sv
// One transfer per memory instruction; memBusy stays high through the memDone cycle
`default_nettype none

module memUnit
	import busPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire execStep,
	input wire memRead,
	input wire memWrite,
	input wire [addrWidth-1:0] address,
	input wire [dataWidth-1:0] storeData,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [addrWidth-1:0] paddr,
	output logic [dataWidth-1:0] pwdata,
	input wire [dataWidth-1:0] prdata,
	input wire pready,
	output logic memBusy,
	output logic memDone,
	output logic [dataWidth-1:0] loadData
);

	apbStateT apbState;
	logic writeReg;
	logic [addrWidth-1:0] addrReg;
	logic [dataWidth-1:0] dataReg;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			apbState <= apbIdle;
			writeReg <= 1'b0;
			memDone <= 1'b0;
		end else begin
			memDone <= 1'b0;
			case (apbState)
				apbIdle: begin
					if (execStep && (memRead || memWrite)) begin
						apbState <= apbSetup;
						writeReg <= memWrite;
					end
				end
				apbSetup: apbState <= apbAccess;
				default: begin
					if (pready) begin
						apbState <= apbIdle;
						writeReg <= 1'b0;
						memDone <= 1'b1;
					end
				end
			endcase
		end
	end

	// Address, store data and load data
	always_ff @(posedge clk) begin
		if (apbState == apbIdle && execStep) begin
			addrReg <= address;
			dataReg <= storeData;
		end
		if (apbState == apbAccess && pready && !writeReg)
			loadData <= prdata;
	end

	assign psel = (apbState != apbIdle);
	assign penable = (apbState == apbAccess);
	assign pwrite = writeReg;
	assign paddr = addrReg;
	assign pwdata = dataReg;
	assign memBusy = psel | memDone;

endmodule

`default_nettype wire

//--- memArbiter.sv
// Data side has priority; the external setup phase is issued when a requester is granted
`default_nettype none

module memArbiter
	import busPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire fetchPsel,
	input wire fetchPenable,
	input wire fetchPwrite,
	input wire [addrWidth-1:0] fetchPaddr,
	input wire [dataWidth-1:0] fetchPwdata,
	output logic [dataWidth-1:0] fetchPrdata,
	output logic fetchPready,
	input wire dataPsel,
	input wire dataPenable,
	input wire dataPwrite,
	input wire [addrWidth-1:0] dataPaddr,
	input wire [dataWidth-1:0] dataPwdata,
	output logic [dataWidth-1:0] dataPrdata,
	output logic dataPready,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [addrWidth-1:0] paddr,
	output logic [dataWidth-1:0] pwdata,
	input wire [dataWidth-1:0] prdata,
	input wire pready
);

	apbStateT busState;
	grantT grant;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busState <= apbIdle;
			grant <= grantNone;
		end else begin
			case (busState)
				apbIdle: begin
					if (dataPsel) begin
						grant <= grantData;
						busState <= apbSetup;
					end else if (fetchPsel) begin
						grant <= grantFetch;
						busState <= apbSetup;
					end
				end
				apbSetup: busState <= apbAccess;
				default: begin
					// Hand over directly to a waiting requester
					if (pready) begin
						if (grant == grantData && fetchPsel) begin
							grant <= grantFetch;
							busState <= apbSetup;
						end else if (grant == grantFetch && dataPsel) begin
							grant <= grantData;
							busState <= apbSetup;
						end else begin
							grant <= grantNone;
							busState <= apbIdle;
						end
					end
				end
			endcase
		end
	end

	always_comb begin
		case (grant)
			grantData: begin
				pwrite = dataPwrite;
				paddr = dataPaddr;
				pwdata = dataPwdata;
			end
			grantFetch: begin
				pwrite = fetchPwrite;
				paddr = fetchPaddr;
				pwdata = fetchPwdata;
			end
			default: begin
				pwrite = 1'b0;
				paddr = '0;
				pwdata = '0;
			end
		endcase
	end

	assign psel = (busState != apbIdle);
	assign penable = (busState == apbAccess);

	assign fetchPrdata = prdata;
	assign dataPrdata = prdata;
	assign fetchPready = pready & penable & fetchPenable & (grant == grantFetch);
	assign dataPready = pready & penable & dataPenable & (grant == grantData);

endmodule

`default_nettype wire

//--- wiscCore.sv
// Memory lives outside the core on the APB port; halted is sticky until reset
`default_nettype none

module wiscCore
	import wiscPkg::*;
	import busPkg::*;
(
	input wire clk,
	input wire rstN,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output logic [addrWidth-1:0] paddr,
	output logic [dataWidth-1:0] pwdata,
	input wire [dataWidth-1:0] prdata,
	input wire pready,
	output logic halted
);

	logic [wordWidth-1:0] instr;
	logic regWrite;
	logic [regAddrWidth-1:0] writeSel;
	logic aluSrc;
	aluOpT aluOp;
	logic extSigned;
	logic immWide;
	logic memWrite;
	logic memRead;
	logic stuCtl;
	logic branchCtl;
	logic jumpCtl;
	logic linkCtl;
	logic halt;

	logic [regAddrWidth-1:0] rsAddr;
	logic [regAddrWidth-1:0] rtAddr;
	logic [wordWidth-1:0] regA;
	logic [wordWidth-1:0] regB;
	logic [wordWidth-1:0] aluResult;
	logic branchTaken;
	logic writeEn;
	logic [wordWidth-1:0] writeData;

	logic execStep;
	logic [addrWidth-1:0] pcPlus2;
	logic memBusy;
	logic memDone;
	logic [dataWidth-1:0] loadData;

	logic fetchPsel;
	logic fetchPenable;
	logic fetchPwrite;
	logic [addrWidth-1:0] fetchPaddr;
	logic [dataWidth-1:0] fetchPwdata;
	logic [dataWidth-1:0] fetchPrdata;
	logic fetchPready;
	logic dataPsel;
	logic dataPenable;
	logic dataPwrite;
	logic [addrWidth-1:0] dataPaddr;
	logic [dataWidth-1:0] dataPwdata;
	logic [dataWidth-1:0] dataPrdata;
	logic dataPready;

	assign rsAddr = instr[10:8];
	assign rtAddr = instr[7:5];

	// ld and stu write back when their transfer is done
	assign writeEn = regWrite & ((memRead | stuCtl) ? memDone : execStep);
	assign writeData = memRead ? loadData : (linkCtl ? pcPlus2 : aluResult);

	control u_control (
		.instr(instr), .regWrite(regWrite), .writeSel(writeSel), .aluSrc(aluSrc),
		.aluOp(aluOp), .extSigned(extSigned), .immWide(immWide), .memWrite(memWrite),
		.memRead(memRead), .stuCtl(stuCtl), .branchCtl(branchCtl), .jumpCtl(jumpCtl),
		.linkCtl(linkCtl), .halt(halt)
	);

	regFile u_regFile (
		.clk(clk), .rstN(rstN), .readAddrA(rsAddr), .readAddrB(rtAddr),
		.writeAddr(writeSel), .writeEn(writeEn), .writeData(writeData),
		.readDataA(regA), .readDataB(regB)
	);

	alu u_alu (
		.instr(instr), .aluOp(aluOp), .aluSrc(aluSrc), .extSigned(extSigned),
		.immWide(immWide), .regA(regA), .regB(regB), .result(aluResult),
		.branchTaken(branchTaken)
	);

	fetchSequencer u_fetchSequencer (
		.clk(clk), .rstN(rstN), .psel(fetchPsel), .penable(fetchPenable),
		.pwrite(fetchPwrite), .paddr(fetchPaddr), .pwdata(fetchPwdata),
		.prdata(fetchPrdata), .pready(fetchPready), .memBusy(memBusy), .memDone(memDone),
		.branchCtl(branchCtl), .jumpCtl(jumpCtl), .linkCtl(linkCtl), .halt(halt),
		.memRead(memRead), .memWrite(memWrite), .branchTaken(branchTaken),
		.instr(instr), .execStep(execStep), .pcPlus2(pcPlus2), .halted(halted)
	);

	memUnit u_memUnit (
		.clk(clk), .rstN(rstN), .execStep(execStep), .memRead(memRead),
		.memWrite(memWrite), .address(aluResult), .storeData(regB),
		.psel(dataPsel), .penable(dataPenable), .pwrite(dataPwrite), .paddr(dataPaddr),
		.pwdata(dataPwdata), .prdata(dataPrdata), .pready(dataPready),
		.memBusy(memBusy), .memDone(memDone), .loadData(loadData)
	);

	memArbiter u_memArbiter (
		.clk(clk), .rstN(rstN),
		.fetchPsel(fetchPsel), .fetchPenable(fetchPenable), .fetchPwrite(fetchPwrite),
		.fetchPaddr(fetchPaddr), .fetchPwdata(fetchPwdata), .fetchPrdata(fetchPrdata),
		.fetchPready(fetchPready),
		.dataPsel(dataPsel), .dataPenable(dataPenable), .dataPwrite(dataPwrite),
		.dataPaddr(dataPaddr), .dataPwdata(dataPwdata), .dataPrdata(dataPrdata),
		.dataPready(dataPready),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready)
	);

endmodule

`default_nettype wire

//--- tbWisc.sv
// 256-word APB memory model with 0 to 3 random wait states; programs are rebuilt per table row
`default_nettype none

module tbWisc;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int clkPeriod = 100;
	localparam int sampleDelay = 2;
	localparam int driveDelay = 5;
	localparam int resetCycles = 10;
	localparam int cyclesPerRow = 200;
	localparam int memWords = 256;
	localparam logic [15:0] resultAddr = 16'h0070;
	localparam logic [15:0] ldStAddr = 16'h0072;
	localparam logic [15:0] stuAddr = 16'h0064;
	localparam logic [15:0] haltWord = 16'h0000;

	// Major opcodes of the instruction set
	localparam logic [4:0] opJ = 5'b00100;
	localparam logic [4:0] opJal = 5'b00110;
	localparam logic [4:0] opAddi = 5'b01000;
	localparam logic [4:0] opSubi = 5'b01001;
	localparam logic [4:0] opXori = 5'b01010;
	localparam logic [4:0] opAndi = 5'b01011;
	localparam logic [4:0] opBeqz = 5'b01100;
	localparam logic [4:0] opBnez = 5'b01101;
	localparam logic [4:0] opBltz = 5'b01110;
	localparam logic [4:0] opBgez = 5'b01111;
	localparam logic [4:0] opSt = 5'b10000;
	localparam logic [4:0] opLd = 5'b10001;
	localparam logic [4:0] opSlbi = 5'b10010;
	localparam logic [4:0] opStu = 5'b10011;
	localparam logic [4:0] opLbi = 5'b11000;
	localparam logic [4:0] opAlu = 5'b11011;
	localparam logic [4:0] opSeq = 5'b11100;
	localparam logic [4:0] opSlt = 5'b11101;
	localparam logic [4:0] opSle = 5'b11110;

	typedef enum int {
		kindAdd, kindSub, kindXor, kindAndn, kindAddi, kindSubi, kindXori, kindAndi,
		kindConst, kindSeq, kindSlt, kindSle, kindBeqz, kindBnez, kindBltz, kindBgez,
		kindJ, kindJal, kindLdSt, kindStu
	} testKindT;

	typedef struct packed {
		testKindT kind;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] expected;
	} testRowT;

	logic clk;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [15:0] paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic pready;
	logic halted;

	logic [15:0] mem [memWords];
	testRowT rows[$];
	bit tableReady;
	int progIndex;
	int valueErrors;
	int protocolErrors;

	wiscCore u_wiscCore (
		.clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] encodeIType(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] encodeRType(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] func);
		return {op, rs, rt, rd, func};
	endfunction

	function automatic logic [15:0] encodeImm8(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	function automatic logic [15:0] encodeJump(input logic [4:0] op, input logic [10:0] disp);
		return {op, disp};
	endfunction

	task automatic addRow(input testKindT kind, input logic [15:0] a, input logic [15:0] b,
		input logic [15:0] expected);
		testRowT row;
		row.kind = kind;
		row.a = a;
		row.b = b;
		row.expected = expected;
		rows.push_back(row);
	endtask

	task automatic buildTable();
		addRow(kindAdd, 16'h1234, 16'h0F0F, 16'h2143);
		addRow(kindSub, 16'h0005, 16'h0100, 16'h00FB);
		addRow(kindXor, 16'hA5A5, 16'h0FF0, 16'hAA55);
		addRow(kindAndn, 16'hFF0F, 16'h0F01, 16'hF00E);
		addRow(kindAddi, 16'h0010, 16'h001F, 16'h000F);
		addRow(kindSubi, 16'h0003, 16'h0010, 16'hFFED);
		addRow(kindXori, 16'h1234, 16'h001F, 16'h122B);
		addRow(kindAndi, 16'hFFF5, 16'h0013, 16'h0011);
		addRow(kindConst, 16'h8A7C, 16'h0000, 16'h8A7C);
		addRow(kindSeq, 16'h1234, 16'h1234, 16'h0001);
		addRow(kindSeq, 16'h1234, 16'h1235, 16'h0000);
		addRow(kindSlt, 16'hFFFE, 16'h0001, 16'h0001);
		addRow(kindSlt, 16'h0001, 16'hFFFE, 16'h0000);
		addRow(kindSle, 16'h0007, 16'h0007, 16'h0001);
		addRow(kindSle, 16'h0008, 16'h0007, 16'h0000);
		// Taken branches keep 0x11, fall-through writes the 0x22 marker
		addRow(kindBeqz, 16'h0000, 16'h0000, 16'h0011);
		addRow(kindBeqz, 16'h0005, 16'h0000, 16'h0022);
		addRow(kindBnez, 16'h0005, 16'h0000, 16'h0011);
		addRow(kindBnez, 16'h0000, 16'h0000, 16'h0022);
		addRow(kindBltz, 16'h8001, 16'h0000, 16'h0011);
		addRow(kindBltz, 16'h0001, 16'h0000, 16'h0022);
		addRow(kindBgez, 16'h0000, 16'h0000, 16'h0011);
		addRow(kindBgez, 16'hFFFF, 16'h0000, 16'h0022);
		addRow(kindJ, 16'h0000, 16'h0000, 16'h0011);
		// jal sits at byte address 10
		addRow(kindJal, 16'h0000, 16'h0000, 16'h000C);
		addRow(kindLdSt, 16'hC35A, 16'h0000, 16'hC35A);
		addRow(kindStu, 16'h1357, 16'h2468, stuAddr);
	endtask

	task automatic fillMemory();
		for (int i = 0; i < memWords; i++)
			mem[i] = 16'hBEEF ^ {i[7:0], ~i[7:0]};
	endtask

	task automatic emitWord(input logic [15:0] word);
		mem[progIndex] = word;
		progIndex++;
	endtask

	task automatic emitSkipTest(input logic [15:0] skipInstr);
		emitWord(encodeImm8(opLbi, 3'd3, 8'h11));
		emitWord(skipInstr);
		emitWord(encodeImm8(opLbi, 3'd3, 8'h22));
	endtask

	// r1 = a, r2 = b, r6 = result base, then the operation into r3
	task automatic buildProgram(input testRowT row);
		progIndex = 0;
		emitWord(encodeImm8(opLbi, 3'd1, row.a[15:8]));
		emitWord(encodeImm8(opSlbi, 3'd1, row.a[7:0]));
		emitWord(encodeImm8(opLbi, 3'd2, row.b[15:8]));
		emitWord(encodeImm8(opSlbi, 3'd2, row.b[7:0]));
		emitWord(encodeImm8(opLbi, 3'd6, resultAddr[7:0]));
		case (row.kind)
			kindAdd: emitWord(encodeRType(opAlu, 3'd1, 3'd2, 3'd3, 2'b00));
			kindSub: emitWord(encodeRType(opAlu, 3'd1, 3'd2, 3'd3, 2'b01));
			kindXor: emitWord(encodeRType(opAlu, 3'd1, 3'd2, 3'd3, 2'b10));
			kindAndn: emitWord(encodeRType(opAlu, 3'd1, 3'd2, 3'd3, 2'b11));
			kindAddi: emitWord(encodeIType(opAddi, 3'd1, 3'd3, row.b[4:0]));
			kindSubi: emitWord(encodeIType(opSubi, 3'd1, 3'd3, row.b[4:0]));
			kindXori: emitWord(encodeIType(opXori, 3'd1, 3'd3, row.b[4:0]));
			kindAndi: emitWord(encodeIType(opAndi, 3'd1, 3'd3, row.b[4:0]));
			kindConst: begin
				emitWord(encodeImm8(opLbi, 3'd3, row.a[15:8]));
				emitWord(encodeImm8(opSlbi, 3'd3, row.a[7:0]));
			end
			kindSeq: emitWord(encodeRType(opSeq, 3'd1, 3'd2, 3'd3, 2'b00));
			kindSlt: emitWord(encodeRType(opSlt, 3'd1, 3'd2, 3'd3, 2'b00));
			kindSle: emitWord(encodeRType(opSle, 3'd1, 3'd2, 3'd3, 2'b00));
			kindBeqz: emitSkipTest(encodeImm8(opBeqz, 3'd1, 8'd2));
			kindBnez: emitSkipTest(encodeImm8(opBnez, 3'd1, 8'd2));
			kindBltz: emitSkipTest(encodeImm8(opBltz, 3'd1, 8'd2));
			kindBgez: emitSkipTest(encodeImm8(opBgez, 3'd1, 8'd2));
			kindJ: emitSkipTest(encodeJump(opJ, 11'd2));
			kindJal: begin
				emitWord(encodeJump(opJal, 11'd2));
				emitWord(encodeImm8(opLbi, 3'd7, 8'h22));
				emitWord(encodeIType(opAddi, 3'd7, 3'd3, 5'd0));
			end
			kindLdSt: begin
				emitWord(encodeIType(opSt, 3'd6, 3'd1, 5'd2));
				emitWord(encodeIType(opLd, 3'd6, 3'd3, 5'd2));
			end
			default: begin
				// stu through r5, then a plain store through the updated base
				emitWord(encodeImm8(opLbi, 3'd5, 8'h60));
				emitWord(encodeIType(opStu, 3'd5, 3'd1, 5'd4));
				emitWord(encodeIType(opSt, 3'd5, 3'd2, 5'd2));
				emitWord(encodeIType(opAddi, 3'd5, 3'd3, 5'd0));
			end
		endcase
		emitWord(encodeIType(opSt, 3'd6, 3'd3, 5'd0));
		emitWord(haltWord);
	endtask

	// APB memory model and bus monitor
	initial begin : apbResponder
		logic ready;
		logic [15:0] readValue;
		logic [7:0] wordIndex;
		logic [31:0] rngState;
		logic inAccess;
		logic setupSeen;
		logic haltedSeen;
		logic firstFetch;
		logic [15:0] setupAddr;
		logic setupWrite;
		logic [15:0] setupData;
		logic [15:0] lastReadWord;
		int waitLeft;
		pready = 1'b0;
		prdata = '0;
		rngState = 32'h36ec;
		inAccess = 1'b0;
		setupSeen = 1'b0;
		haltedSeen = 1'b0;
		firstFetch = 1'b1;
		setupAddr = '0;
		setupWrite = 1'b0;
		setupData = '0;
		lastReadWord = 16'hFFFF;
		waitLeft = 0;
		forever begin
			@(posedge clk);
			#sampleDelay;
			ready = 1'b0;
			readValue = '0;
			wordIndex = paddr[8:1];
			if (!rstN) begin
				if (psel !== 1'b0 || penable !== 1'b0 ||
					pwrite !== 1'b0 || halted !== 1'b0) begin
					$display("ERROR t=%0t: bus strobes or halted not low during reset", $time);
					protocolErrors++;
				end
				inAccess = 1'b0;
				setupSeen = 1'b0;
				haltedSeen = 1'b0;
				firstFetch = 1'b1;
				lastReadWord = 16'hFFFF;
			end else begin
				if (psel && !penable) begin
					if (setupSeen) begin
						$display("ERROR t=%0t: setup phase lasted more than one cycle", $time);
						protocolErrors++;
					end
					if (firstFetch) begin
						if (paddr !== 16'h0000) begin
							$display("FAILED t=%0t paddr: got %h expected %h", $time, paddr, 16'h0000);
							valueErrors++;
						end
						if (pwrite !== 1'b0) begin
							$display("FAILED t=%0t pwrite: got %b expected %b", $time, pwrite, 1'b0);
							valueErrors++;
						end
						firstFetch = 1'b0;
					end
					setupSeen = 1'b1;
					setupAddr = paddr;
					setupWrite = pwrite;
					setupData = pwdata;
				end else if (psel && penable) begin
					if (!setupSeen && !inAccess) begin
						$display("ERROR t=%0t: access phase without a setup phase", $time);
						protocolErrors++;
					end
					if (paddr !== setupAddr) begin
						$display("FAILED t=%0t paddr: got %h expected %h", $time, paddr, setupAddr);
						valueErrors++;
					end
					if (pwrite !== setupWrite) begin
						$display("FAILED t=%0t pwrite: got %b expected %b", $time, pwrite, setupWrite);
						valueErrors++;
					end
					if (setupWrite && pwdata !== setupData) begin
						$display("FAILED t=%0t pwdata: got %h expected %h", $time, pwdata, setupData);
						valueErrors++;
					end
					if (!inAccess) begin
						rngState = xorshift32(rngState);
						waitLeft = rngState % 4;
						inAccess = 1'b1;
					end
					setupSeen = 1'b0;
					if (waitLeft == 0) begin
						ready = 1'b1;
						inAccess = 1'b0;
						if (paddr[15:9] != 7'd0 || paddr[0]) begin
							$display("ERROR t=%0t: address %h outside the memory", $time, paddr);
							protocolErrors++;
						end else if (pwrite) begin
							mem[wordIndex] = pwdata;
						end else begin
							readValue = mem[wordIndex];
							lastReadWord = readValue;
						end
					end else begin
						waitLeft--;
					end
				end else begin
					if (penable) begin
						$display("ERROR t=%0t: penable high without psel", $time);
						protocolErrors++;
					end
					if (setupSeen || inAccess) begin
						$display("ERROR t=%0t: transfer dropped before pready", $time);
						protocolErrors++;
					end
					setupSeen = 1'b0;
					inAccess = 1'b0;
				end
				if (haltedSeen && !halted) begin
					$display("ERROR t=%0t: halted fell without a reset", $time);
					protocolErrors++;
				end
				if (halted && !haltedSeen) begin
					haltedSeen = 1'b1;
					if (lastReadWord !== haltWord) begin
						$display("ERROR t=%0t: halted rose without a halt being fetched", $time);
						protocolErrors++;
					end
				end
				if (haltedSeen && psel) begin
					$display("ERROR t=%0t: bus activity after halted", $time);
					protocolErrors++;
				end
			end
			#(driveDelay - sampleDelay);
			pready = ready;
			prdata = readValue;
		end
	end

	initial begin : watchdog
		int limit;
		int cycleCount;
		wait (tableReady);
		limit = rows.size() * cyclesPerRow;
		cycleCount = 0;
		while (cycleCount < limit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("ERROR: timeout after %0d cycles", cycleCount);
		$display("Error counts: %0d value, %0d protocol", valueErrors, protocolErrors);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin : mainFlow
		testRowT row;
		rstN = 1'b0;
		valueErrors = 0;
		protocolErrors = 0;
		buildTable();
		tableReady = 1'b1;
		for (int r = 0; r < rows.size(); r++) begin
			row = rows[r];
			fillMemory();
			buildProgram(row);
			repeat (resetCycles) @(posedge clk);
			#driveDelay;
			rstN = 1'b1;
			@(posedge clk);
			#sampleDelay;
			while (!halted) begin
				@(posedge clk);
				#sampleDelay;
			end
			// A few more cycles so the monitor sees halted held
			repeat (3) @(posedge clk);
			if (mem[resultAddr[8:1]] !== row.expected) begin
				$display("FAILED t=%0t row %0d mem[%h]: got %h expected %h", $time, r,
					resultAddr, mem[resultAddr[8:1]], row.expected);
				valueErrors++;
			end
			if (row.kind == kindLdSt && mem[ldStAddr[8:1]] !== row.a) begin
				$display("FAILED t=%0t row %0d mem[%h]: got %h expected %h", $time, r,
					ldStAddr, mem[ldStAddr[8:1]], row.a);
				valueErrors++;
			end
			if (row.kind == kindStu && mem[stuAddr[8:1]] !== row.a) begin
				$display("FAILED t=%0t row %0d mem[%h]: got %h expected %h", $time, r,
					stuAddr, mem[stuAddr[8:1]], row.a);
				valueErrors++;
			end
			if (row.kind == kindStu && mem[stuAddr[8:1] + 8'd1] !== row.b) begin
				$display("FAILED t=%0t row %0d mem[%h]: got %h expected %h", $time, r,
					stuAddr + 16'd2, mem[stuAddr[8:1] + 8'd1], row.b);
				valueErrors++;
			end
			#driveDelay;
			rstN = 1'b0;
		end
		$display("Error counts: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
wiscPkg.sv
busPkg.sv
control.sv
regFile.sv
alu.sv
fetchSequencer.sv
memUnit.sv
memArbiter.sv
wiscCore.sv
tbWisc.sv
